// File: dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_COUNT_W     14
`define DMA_HALF_W      16
`define DMA_VIDEO_W     16

// blank positions, compared against the low byte of the video counters
`define DMA_HBLANK_COL  8'd240
`define DMA_VBLANK_LINE 8'd160

`define DMA_STEP_HALF   3'd2
`define DMA_STEP_WORD   3'd4

`define DMA_REG_SEL_W   2
`define DMA_REG_SAD     2'd0
`define DMA_REG_DAD     2'd1
`define DMA_REG_CNT     2'd2

`endif

// File: dma_pkg.sv
`default_nettype none
`include "dma_defines.svh"

package dma_pkg;

  typedef enum logic [1:0] {
    ADDR_INC        = 2'd0,
    ADDR_DEC        = 2'd1,
    ADDR_FIXED      = 2'd2,
    ADDR_INC_RELOAD = 2'd3
  } addrCtl_e;

  typedef enum logic [1:0] {
    START_IMM    = 2'd0,
    START_VBLANK = 2'd1,
    START_HBLANK = 2'd2,
    START_REQ    = 2'd3
  } startMode_e;

  // control/count word as software writes it
  typedef struct packed {
    logic                          enable;    // 31
    logic                          irqEn;
    startMode_e                    startMode; // 29:28
    logic                          rsvdHi;
    logic                          wordSize;  // 26
    logic                          repeatEn;
    addrCtl_e                      srcCtl;    // 24:23
    addrCtl_e                      dstCtl;    // 22:21
    logic [4:0]                    rsvdMid;
    logic [15-`DMA_COUNT_W:0]      rsvdLo;
    logic [`DMA_COUNT_W-1:0]       count;
  } dmaCtrl_t;

  typedef struct packed {
    logic                   valid;
    logic                   wen;
    logic [1:0]             size;  // 1 halfword, 2 word
    logic [`DMA_ADDR_W-1:0] addr;
    logic [`DMA_DATA_W-1:0] wdata;
  } memReq_t;

endpackage : dma_pkg

`default_nettype wire

// File: dmaRegs.sv
`default_nettype none
`timescale 1ns/1ps
`include "dma_defines.svh"

module dmaRegs (
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      regWr,
  input  logic [`DMA_REG_SEL_W-1:0] regSel,
  input  logic [`DMA_DATA_W-1:0]    regData,
  input  logic                      blockEnd,
  output dma_pkg::dmaCtrl_t         cfg,
  output logic [`DMA_ADDR_W-1:0]    srcBase,
  output logic [`DMA_ADDR_W-1:0]    dstBase,
  output logic                      arm
);
  import dma_pkg::*;

  dmaCtrl_t wrCtrl;

  assign wrCtrl = dmaCtrl_t'(regData);

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      cfg     <= '0;
      srcBase <= '0;
      dstBase <= '0;
      arm     <= 1'b0;
    end else begin
      arm <= 1'b0;
      if (blockEnd)
        cfg.enable <= 1'b0; // block done, channel goes quiet
      if (regWr) begin
        case (regSel)
          `DMA_REG_SAD: srcBase <= regData;
          `DMA_REG_DAD: dstBase <= regData;
          `DMA_REG_CNT: begin
            cfg <= wrCtrl;
            // only a rising enable arms a new block
            arm <= wrCtrl.enable & (~cfg.enable | blockEnd);
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule : dmaRegs

`default_nettype wire

// File: dmaTrigger.sv
`default_nettype none
`timescale 1ns/1ps
`include "dma_defines.svh"

module dmaTrigger (
  input  logic                    clk,
  input  logic                    rst_b,
  input  dma_pkg::dmaCtrl_t       cfg,
  input  logic [`DMA_VIDEO_W-1:0] hcount,
  input  logic [`DMA_VIDEO_W-1:0] vcount,
  input  logic                    reqStrobe,
  output logic                    go
);
  import dma_pkg::*;

  logic reqDly;
  logic startCond;

  always_comb begin
    case (cfg.startMode)
      START_IMM:    startCond = 1'b1;
      START_VBLANK: startCond = (vcount[7:0] == `DMA_VBLANK_LINE);
      START_HBLANK: startCond = (hcount[7:0] == `DMA_HBLANK_COL);
      START_REQ:    startCond = reqDly;
    endcase
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      reqDly <= 1'b0;
      go     <= 1'b0;
    end else begin
      reqDly <= reqStrobe; // breaks the path from the requester
      go     <= cfg.enable & startCond;
    end
  end

endmodule : dmaTrigger

`default_nettype wire

// File: dmaSequencer.sv
`default_nettype none
`timescale 1ns/1ps

module dmaSequencer (
  input  logic              clk,
  input  logic              rst_b,
  input  dma_pkg::dmaCtrl_t cfg,
  input  logic              arm,
  input  logic              go,
  input  logic              memWait,
  input  logic              lastUnit,
  output logic              load,
  output logic              reloadBlock,
  output logic              stepSrc,
  output logic              stepDst,
  output logic              storeData,
  output logic              writePhase,
  output logic              reqValid,
  output logic              blockEnd,
  output logic              irq
);

  typedef enum logic [2:0] {OFF, IDLE, QUEUED, READ, WRITE} state_e;

  state_e state, nextState;
  logic   finishUnit;

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      state <= OFF;
      irq   <= 1'b0;
    end else begin
      state <= nextState;
      irq   <= finishUnit & lastUnit & cfg.irqEn;
    end
  end

  assign finishUnit = (state == WRITE) && !memWait;
  assign reqValid   = (state == READ) || (state == WRITE);
  assign writePhase = (state == WRITE);

  always_comb begin
    nextState   = state;
    load        = 1'b0;
    reloadBlock = 1'b0;
    stepSrc     = 1'b0;
    stepDst     = 1'b0;
    storeData   = 1'b0;
    blockEnd    = 1'b0;
    case (state)
      OFF, IDLE, QUEUED: begin
        if (arm) begin
          load      = 1'b1;
          nextState = IDLE;
        end else if (state == OFF || !cfg.enable) begin
          nextState = OFF;
        end else if (state == QUEUED || go) begin
          nextState = memWait ? QUEUED : READ; // bus busy, hold the start
        end
      end
      READ: begin
        if (!memWait) begin
          storeData = 1'b1;
          stepSrc   = 1'b1;
          nextState = WRITE;
        end
      end
      WRITE: begin
        if (finishUnit) begin
          stepDst = 1'b1;
          if (!lastUnit) begin
            nextState = READ;
          end else if (cfg.repeatEn) begin
            reloadBlock = 1'b1;
            nextState   = IDLE;
          end else begin
            blockEnd  = 1'b1;
            nextState = OFF;
          end
        end
      end
      default: nextState = OFF;
    endcase
  end

endmodule : dmaSequencer

`default_nettype wire

// File: dmaAddrPath.sv
`default_nettype none
`timescale 1ns/1ps
`include "dma_defines.svh"

module dmaAddrPath (
  input  logic                   clk,
  input  logic                   rst_b,
  input  dma_pkg::dmaCtrl_t      cfg,
  input  logic [`DMA_ADDR_W-1:0] srcBase,
  input  logic [`DMA_ADDR_W-1:0] dstBase,
  input  logic                   load,
  input  logic                   reloadBlock,
  input  logic                   stepSrc,
  input  logic                   stepDst,
  input  logic                   storeData,
  input  logic                   writePhase,
  input  logic                   reqValid,
  input  logic [`DMA_DATA_W-1:0] rdata,
  output logic                   lastUnit,
  output dma_pkg::memReq_t       memReq
);
  import dma_pkg::*;

  logic [`DMA_ADDR_W-1:0]  srcAddr;
  logic [`DMA_ADDR_W-1:0]  dstAddr;
  logic [2:0]              stepSize;
  logic [`DMA_COUNT_W-1:0] countReg;
  logic [`DMA_COUNT_W-1:0] unitCnt;
  logic [`DMA_DATA_W-1:0]  dataLatch;
  logic [`DMA_DATA_W-1:0]  wdata;

  function automatic logic [`DMA_ADDR_W-1:0] stepAddr(
    input logic [`DMA_ADDR_W-1:0] addr,
    input addrCtl_e               ctl,
    input logic [2:0]             step
  );
    case (ctl)
      ADDR_DEC:   stepAddr = addr - `DMA_ADDR_W'(step);
      ADDR_FIXED: stepAddr = addr;
      default:    stepAddr = addr + `DMA_ADDR_W'(step); // inc and inc-reload
    endcase
  endfunction

  assign stepSize = cfg.wordSize ? `DMA_STEP_WORD : `DMA_STEP_HALF;

  always_ff @(posedge clk) begin
    if (load) begin
      srcAddr <= srcBase;
      dstAddr <= dstBase;
    end else begin
      if (stepSrc)
        srcAddr <= stepAddr(srcAddr, cfg.srcCtl, stepSize);
      // reload wins over the step of the last unit
      if (reloadBlock && cfg.dstCtl == ADDR_INC_RELOAD)
        dstAddr <= dstBase;
      else if (stepDst)
        dstAddr <= stepAddr(dstAddr, cfg.dstCtl, stepSize);
    end
    if (storeData)
      dataLatch <= rdata;
  end

  always_ff @(posedge clk, negedge rst_b) begin
    if (!rst_b) begin
      unitCnt  <= '0;
      countReg <= '0;
    end else if (load || reloadBlock) begin
      unitCnt  <= '0;
      countReg <= cfg.count;
    end else if (stepDst) begin
      unitCnt <= unitCnt + 1'b1;
    end
  end

  // a count of 0 wraps to the full 16384 units
  assign lastUnit = (unitCnt == countReg - 1'b1);

  always_comb begin
    wdata = dataLatch;
    if (!cfg.wordSize && dstAddr[1])
      wdata[`DMA_DATA_W-1 -: `DMA_HALF_W] = dataLatch[`DMA_HALF_W-1:0]; // upper lane
  end

  assign memReq = '{
    valid: reqValid,
    wen:   writePhase,
    size:  cfg.wordSize ? 2'd2 : 2'd1,
    addr:  writePhase ? dstAddr : srcAddr,
    wdata: wdata
  };

endmodule : dmaAddrPath

`default_nettype wire

// File: dmaTop.sv
`default_nettype none
`timescale 1ns/1ps
`include "dma_defines.svh"

module dmaTop (
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      regWr,
  input  logic [`DMA_REG_SEL_W-1:0] regSel,
  input  logic [`DMA_DATA_W-1:0]    regData,
  input  logic [`DMA_VIDEO_W-1:0]   hcount,
  input  logic [`DMA_VIDEO_W-1:0]   vcount,
  input  logic                      reqStrobe,
  input  logic [`DMA_DATA_W-1:0]    rdata,
  input  logic                      memWait,
  output dma_pkg::memReq_t          memReq,
  output logic                      irq,
  output logic                      enabled
);
  import dma_pkg::*;

  dmaCtrl_t               cfg;
  logic [`DMA_ADDR_W-1:0] srcBase, dstBase;
  logic                   arm, go, blockEnd, lastUnit, reqValid;
  logic                   load, reloadBlock, stepSrc, stepDst, storeData, writePhase;

  assign enabled = cfg.enable;

  dmaRegs regs_i (
    .clk, .rst_b, .regWr, .regSel, .regData, .blockEnd,
    .cfg, .srcBase, .dstBase, .arm
  );

  dmaTrigger trig_i (
    .clk, .rst_b, .cfg, .hcount, .vcount, .reqStrobe, .go
  );

  dmaSequencer seq_i (
    .clk, .rst_b, .cfg, .arm, .go, .memWait, .lastUnit,
    .load, .reloadBlock, .stepSrc, .stepDst, .storeData, .writePhase,
    .reqValid, .blockEnd, .irq
  );

  dmaAddrPath path_i (
    .clk, .rst_b, .cfg, .srcBase, .dstBase,
    .load, .reloadBlock, .stepSrc, .stepDst, .storeData, .writePhase,
    .reqValid, .rdata, .lastUnit, .memReq
  );

endmodule : dmaTop

`default_nettype wire

// File: dma_properties.sv
`default_nettype none
`timescale 1ns/1ps

module dma_properties (
  input logic             clk,
  input logic             rst_b,
  input dma_pkg::memReq_t memReq,
  input logic             memWait,
  input logic             irq,
  input logic             enabled,
  input logic             blockEnd
);

  // a stalled request keeps every field until memory accepts it
  holdUnderWait: assert property (@(posedge clk) disable iff (!rst_b)
    (memReq.valid && memWait) |=> $stable(memReq))
    else $error("memReq changed while memWait was high");

  irqSinglePulse: assert property (@(posedge clk) disable iff (!rst_b)
    irq |=> !irq)
    else $error("irq high on two consecutive cycles");

  // only the finishing write may overlap the enable going low
  noReqWhenOff: assert property (@(posedge clk) disable iff (!rst_b)
    memReq.valid |-> (enabled || blockEnd))
    else $error("memReq.valid high while the channel is disabled");

endmodule : dma_properties

bind dmaTop dma_properties props_i (
  .clk(clk), .rst_b(rst_b), .memReq(memReq), .memWait(memWait),
  .irq(irq), .enabled(enabled), .blockEnd(blockEnd)
);

`default_nettype wire

// File: dma_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb;
  import dma_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int TEST_COUNT  = 5;
  localparam int TEST_CYCLES = 1000; // generous bound per test, stalls included
  localparam int WATCHDOG_NS = TEST_COUNT * TEST_CYCLES * CLK_PERIOD;
  localparam logic [31:0] READ_KEY = 32'hA5A5_5A5A;

  logic                      clk = 1'b0;
  logic                      rst_b;
  logic                      regWr;
  logic [`DMA_REG_SEL_W-1:0] regSel;
  logic [`DMA_DATA_W-1:0]    regData;
  logic [`DMA_VIDEO_W-1:0]   hcount;
  logic [`DMA_VIDEO_W-1:0]   vcount;
  logic                      reqStrobe;
  logic [`DMA_DATA_W-1:0]    rdata;
  logic                      memWait = 1'b0;
  memReq_t                   memReq;
  logic                      irq;
  logic                      enabled;

  integer      seed = 32'h5601_172c;
  bit          stallOn = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          irqCount = 0;
  int          validCount = 0;
  logic [31:0] logAddr[$];
  logic [31:0] logData[$];
  logic [1:0]  logSize[$];

  dmaTop dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign rdata = memReq.addr ^ READ_KEY; // memory read port, answers in the same cycle

  always @(posedge clk)
    memWait <= stallOn && (($random(seed) & 3) == 0);

  // write log, taken mid-cycle where the bus is stable
  always @(negedge clk) begin
    if (rst_b && memReq.valid && memReq.wen && !memWait) begin
      logAddr.push_back(memReq.addr);
      logData.push_back(memReq.wdata);
      logSize.push_back(memReq.size);
    end
    if (memReq.valid)
      validCount++;
    if (irq)
      irqCount++;
  end

  task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkWrite(input int idx, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] mask, input logic [1:0] size);
    assert (idx < logAddr.size()) else begin
      errors++;
      $display("write %0d never reached the memory", idx);
    end
    if (idx < logAddr.size()) begin
      checkEqual($sformatf("memReq.addr[%0d]", idx), logAddr[idx], addr);
      checkEqual($sformatf("memReq.wdata[%0d]", idx), logData[idx] & mask, data & mask);
      checkEqual($sformatf("memReq.size[%0d]", idx), 32'(logSize[idx]), 32'(size));
    end
  endtask

  function automatic logic [31:0] packCtrl(input bit irqEn, input startMode_e mode,
      input bit word, input bit rpt, input addrCtl_e srcCtl, input addrCtl_e dstCtl,
      input logic [`DMA_COUNT_W-1:0] count);
    dmaCtrl_t c;
    c           = '0;
    c.enable    = 1'b1;
    c.irqEn     = irqEn;
    c.startMode = mode;
    c.wordSize  = word;
    c.repeatEn  = rpt;
    c.srcCtl    = srcCtl;
    c.dstCtl    = dstCtl;
    c.count     = count;
    return c;
  endfunction

  task automatic writeReg(input logic [`DMA_REG_SEL_W-1:0] sel, input logic [31:0] data);
    @(posedge clk);
    regWr   <= 1'b1;
    regSel  <= sel;
    regData <= data;
    @(posedge clk);
    regWr <= 1'b0;
  endtask

  task automatic programBlock(input logic [31:0] src, input logic [31:0] dst,
                              input logic [31:0] ctrl);
    writeReg(`DMA_REG_SAD, src);
    writeReg(`DMA_REG_DAD, dst);
    writeReg(`DMA_REG_CNT, ctrl); // enable rises here
  endtask

  task automatic pulseRequest;
    @(posedge clk);
    reqStrobe <= 1'b1;
    @(posedge clk);
    reqStrobe <= 1'b0;
  endtask

  task automatic waitDisabled(input int maxCycles);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (enabled && n < maxCycles);
    assert (!enabled) else begin
      errors++;
      $display("block did not finish within %0d cycles", maxCycles);
    end
    repeat (3) @(negedge clk); // let irq and the log settle
  endtask

  task automatic waitWrites(input int target, input int maxCycles);
    int n;
    n = 0;
    while (logAddr.size() < target && n < maxCycles) begin
      @(posedge clk);
      n++;
    end
    assert (logAddr.size() >= target) else begin
      errors++;
      $display("only %0d of %0d writes seen within %0d cycles", logAddr.size(), target,
               maxCycles);
    end
  endtask

  // word copy with both addresses counting up
  task automatic checkWordRun(input int base, input int n, input logic [31:0] src,
                              input logic [31:0] dst);
    int i;
    checkEqual("write count", logAddr.size() - base, n);
    for (i = 0; i < n; i++)
      checkWrite(base + i, dst + 4 * i, (src + 4 * i) ^ READ_KEY, '1, 2'd2);
  endtask

  task automatic wordCopyTest(input bit stalls);
    int base;
    int irqBase;
    base    = logAddr.size();
    irqBase = irqCount;
    stallOn <= stalls;
    programBlock(32'h1000, 32'h2000,
                 packCtrl(1'b1, START_IMM, 1'b1, 1'b0, ADDR_INC, ADDR_INC, 14'd5));
    waitDisabled(TEST_CYCLES / 2);
    stallOn <= 1'b0;
    checkWordRun(base, 5, 32'h1000, 32'h2000);
    checkEqual("irq pulses", irqCount - irqBase, 1);
    checkEqual("enabled", 32'(enabled), 0);
  endtask

  task automatic halfwordTest;
    logic [31:0] rd;
    int          base;
    int          i;
    base = logAddr.size();
    programBlock(32'h3010, 32'h4002, // dst bit 1 set, upper lane
                 packCtrl(1'b0, START_IMM, 1'b0, 1'b0, ADDR_DEC, ADDR_FIXED, 14'd3));
    waitDisabled(TEST_CYCLES / 2);
    checkEqual("write count", logAddr.size() - base, 3);
    for (i = 0; i < 3; i++) begin
      rd = (32'h3010 - 2 * i) ^ READ_KEY;
      checkWrite(base + i, 32'h4002, {rd[15:0], 16'h0000}, 32'hFFFF_0000, 2'd1);
    end
  endtask

  task automatic vblankTest;
    int base;
    int validBase;
    int line;
    base = logAddr.size();
    @(posedge clk);
    vcount <= 16'd150;
    programBlock(32'h7000, 32'h8000,
                 packCtrl(1'b0, START_VBLANK, 1'b1, 1'b0, ADDR_INC, ADDR_INC, 14'd4));
    validBase = validCount;
    for (line = 151; line < 160; line++) begin
      repeat (4) @(posedge clk);
      vcount <= 16'(line);
    end
    repeat (4) @(posedge clk);
    checkEqual("memReq.valid cycles before vblank", validCount - validBase, 0);
    vcount <= `DMA_VIDEO_W'(`DMA_VBLANK_LINE);
    waitDisabled(TEST_CYCLES / 2);
    @(posedge clk);
    vcount <= 16'd0;
    checkWordRun(base, 4, 32'h7000, 32'h8000);
  endtask

  task automatic repeatReqTest;
    int base;
    int irqBase;
    int blk;
    int u;
    base    = logAddr.size();
    irqBase = irqCount;
    programBlock(32'h5000, 32'h6000,
                 packCtrl(1'b1, START_REQ, 1'b1, 1'b1, ADDR_INC, ADDR_INC_RELOAD, 14'd2));
    repeat (8) @(posedge clk);
    checkEqual("writes before request", logAddr.size() - base, 0);
    for (blk = 0; blk < 2; blk++) begin
      pulseRequest();
      waitWrites(base + 2 * (blk + 1), TEST_CYCLES / 4);
      repeat (4) @(posedge clk);
    end
    checkEqual("write count", logAddr.size() - base, 4);
    // dst restarts each block, src carries on
    for (blk = 0; blk < 2; blk++)
      for (u = 0; u < 2; u++)
        checkWrite(base + 2 * blk + u, 32'h6000 + 4 * u,
                   (32'h5000 + 8 * blk + 4 * u) ^ READ_KEY, '1, 2'd2);
    checkEqual("irq pulses", irqCount - irqBase, 2);
    checkEqual("enabled", 32'(enabled), 1);
    writeReg(`DMA_REG_CNT, 32'd0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_b     = 1'b0;
    regWr     = 1'b0;
    regSel    = '0;
    regData   = '0;
    hcount    = '0;
    vcount    = '0;
    reqStrobe = 1'b0;
    repeat (10) @(posedge clk);
    rst_b <= 1'b1;
    repeat (2) @(posedge clk);
    wordCopyTest(1'b0);
    halfwordTest();
    vblankTest();
    repeatReqTest();
    wordCopyTest(1'b1); // random memWait
    repeat (4) @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : dma_tb

`default_nettype wire

// File: verilog.f
+incdir+.
dma_pkg.sv
dmaRegs.sv
dmaTrigger.sv
dmaSequencer.sv
dmaAddrPath.sv
dmaTop.sv
dma_properties.sv
dma_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := dma_tb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
